/* lru_defs.svh */
// Set and way counts must be powers of two; ways 2 to 128, sets at least 2, pipe depth at least 1
`ifndef LRU_DEFS_SVH
`define LRU_DEFS_SVH

// ==============================
// Array geometry
// ==============================

// Number of sets in the TLB
`define LRU_NUM_SETS      16

// Ways per set, LRU order list length
`define LRU_NUM_WAYS      4

// ==============================
// Read pipe
// ==============================

`define LRU_PIPE_STAGES   2      // Default read latency in cycles

// ==============================
// Derived widths
// ==============================

`define LRU_SET_W         $clog2(`LRU_NUM_SETS)   // Set address bits
`define LRU_WAY_W         $clog2(`LRU_NUM_WAYS)   // Way id bits

`endif

/* lru_pkg.sv */
// Types sized from the defines header; order entry 0 is always the LRU way
`default_nettype none

`include "lru_defs.svh"

package lru_pkg;

   // ==============================
   // Basic fields
   // ==============================
   typedef logic [`LRU_SET_W-1:0]    set_addr_t;   // Set address
   typedef logic [`LRU_WAY_W-1:0]    way_id_t;     // One way id
   typedef logic [`LRU_NUM_WAYS-1:0] way_vec_t;    // One bit per way

   // Packed order of one set, entry NUM_WAYS-1 is the MRU way
   typedef way_id_t [`LRU_NUM_WAYS-1:0] lru_order_t;

   // Write classification
   typedef enum logic [1:0] {
      WR_HIT        = 2'd0,   // Hit way to MRU
      WR_REPLACE    = 2'd1,   // Replaced way to MRU
      WR_INVALIDATE = 2'd2    // Back to identity order
   } wr_kind_e;

   // Identity order, position i holds way i
   function automatic lru_order_t identity_order();
      lru_order_t ord;
      for (int i = 0; i < `LRU_NUM_WAYS; i++) begin
         ord[i] = way_id_t'(i);
      end
      return ord;
   endfunction

endpackage

`default_nettype wire

/* lru_order_update.sv */
// Purely combinational; hit must be one-hot or zero, replace one-hot, all-ones or zero
`timescale 1ns/1ns
`default_nettype none

`include "lru_defs.svh"

module lru_order_update (
   input  lru_pkg::lru_order_t cur_order,
   input  lru_pkg::way_vec_t   hit_vec,
   input  lru_pkg::way_vec_t   rep_vec,
   output lru_pkg::lru_order_t new_order,
   output lru_pkg::wr_kind_e   kind
);

   import lru_pkg::*;

   localparam int NUM_WAYS = `LRU_NUM_WAYS;

   way_vec_t                sel_vec;    // Way that moves to MRU
   logic [NUM_WAYS-1:0]     pos_hit;    // Order positions holding the selected way
   logic [NUM_WAYS-2:0]     shift_en;   // Positions at or above the selected one
   logic                    seen;
   logic                    found;
   way_id_t                 sel_way;
   lru_order_t              moved_order;

   // ==============================
   // Write classification
   // ==============================
   always_comb begin
      if (|hit_vec) begin
         kind = WR_HIT;
      end else if ((&rep_vec) || (~|rep_vec)) begin
         kind = WR_INVALIDATE;   // All-ones or empty replace
      end else begin
         kind = WR_REPLACE;
      end
   end

   assign sel_vec = (kind == WR_HIT) ? hit_vec : rep_vec;

   // ==============================
   // Locate selected way
   // ==============================
   always_comb begin
      sel_way = '0;
      for (int i = 0; i < NUM_WAYS; i++) begin
         pos_hit[i] = sel_vec[cur_order[i]];
         if (pos_hit[i]) begin
            sel_way = cur_order[i];
         end
      end
   end

   // Prefix OR so everything from the hit position upward shifts down
   always_comb begin
      seen = 1'b0;
      for (int i = 0; i < NUM_WAYS - 1; i++) begin
         seen        = seen | pos_hit[i];
         shift_en[i] = seen;
      end
      found = seen | pos_hit[NUM_WAYS-1];
   end

   // ==============================
   // New order
   // ==============================
   always_comb begin
      for (int i = 0; i < NUM_WAYS - 1; i++) begin
         moved_order[i] = shift_en[i] ? cur_order[i+1] : cur_order[i];
      end
      // Selected way lands at MRU; order kept if the way was not found
      moved_order[NUM_WAYS-1] = found ? sel_way : cur_order[NUM_WAYS-1];
   end

   assign new_order = (kind == WR_INVALIDATE) ? identity_order() : moved_order;

endmodule

`default_nettype wire

/* lru_state_array.sv */
// One write port; write lands at the next edge, both read ports are combinational
`timescale 1ns/1ns
`default_nettype none

`include "lru_defs.svh"

module lru_state_array (
   input  logic                clk,
   input  logic                rst,
   input  logic                lru_reset,      // Global return to identity order
   input  logic                wr_en,
   input  lru_pkg::set_addr_t  wr_set,
   input  lru_pkg::lru_order_t wr_new_order,
   input  lru_pkg::set_addr_t  rd_addr_q,
   output lru_pkg::lru_order_t wr_cur_order,
   output lru_pkg::lru_order_t rd_order
);

   import lru_pkg::*;

   localparam int NUM_SETS = `LRU_NUM_SETS;

   lru_order_t              order_q [NUM_SETS];   // Per-set order storage
   logic [NUM_SETS-1:0]     set_wr;               // Decoded set write enables
   logic                    clear_all;

   // ==============================
   // Write decode
   // ==============================
   assign clear_all = rst | lru_reset;   // Takes priority over wr_en

   always_comb begin
      for (int s = 0; s < NUM_SETS; s++) begin
         set_wr[s] = wr_en && (wr_set == set_addr_t'(s));
      end
   end

   // ==============================
   // Storage
   // ==============================
   always_ff @(posedge clk) begin
      for (int s = 0; s < NUM_SETS; s++) begin
         if (clear_all) begin
            order_q[s] <= identity_order();
         end else if (set_wr[s]) begin
            order_q[s] <= wr_new_order;
         end
      end
   end

   // ==============================
   // Read ports
   // ==============================

   // Current order of the set being written, feeds the update logic
   assign wr_cur_order = order_q[wr_set];

   assign rd_order     = order_q[rd_addr_q];   // Read pipe port

endmodule

`default_nettype wire

/* lru_read_pipe.sv */
// Fixed latency of PIPE_STAGES cycles from rd_en; no back-pressure, one read per cycle
`timescale 1ns/1ns
`default_nettype none

`include "lru_defs.svh"

module lru_read_pipe #(
   parameter int PIPE_STAGES = `LRU_PIPE_STAGES   // Minimum 1
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                rd_en,
   input  lru_pkg::set_addr_t  rd_set,
   input  lru_pkg::lru_order_t rd_order,
   output lru_pkg::set_addr_t  rd_addr_q,
   output logic                rd_valid,
   output lru_pkg::way_vec_t   rd_way_vec,
   output lru_pkg::way_vec_t   rd_way2_vec
);

   import lru_pkg::*;

   logic [PIPE_STAGES:1]    vld_q;                   // Per-stage valid
   lru_order_t              stg_order [1:PIPE_STAGES];
   lru_order_t              last_order;
   way_id_t                 lru_id;
   way_id_t                 lru2_id;

   // ==============================
   // Address stage
   // ==============================
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_addr_q <= rd_set;
      end
   end

   // Stage 1 is the array output at the registered address
   assign stg_order[1] = rd_order;

   // ==============================
   // Extra latency stages
   // ==============================
   always_ff @(posedge clk) begin
      if (rst) begin
         vld_q <= '0;
      end else begin
         vld_q[1] <= rd_en;
         for (int k = 2; k <= PIPE_STAGES; k++) begin
            vld_q[k] <= vld_q[k-1];
         end
      end
   end

   for (genvar k = 2; k <= PIPE_STAGES; k++) begin : g_stage
      always_ff @(posedge clk) begin
         if (vld_q[k-1]) begin   // Only move real reads
            stg_order[k] <= stg_order[k-1];
         end
      end
   end

   // ==============================
   // Output decode
   // ==============================
   assign last_order = stg_order[PIPE_STAGES];
   assign lru_id     = last_order[0];   // LRU way
   assign lru2_id    = last_order[1];   // Second LRU way
   assign rd_valid   = vld_q[PIPE_STAGES];

   always_comb begin
      rd_way_vec           = '0;
      rd_way2_vec          = '0;
      rd_way_vec[lru_id]   = 1'b1;
      rd_way2_vec[lru2_id] = 1'b1;
   end

endmodule

`default_nettype wire

/* lru_top.sv */
// Single write port; a write in the same cycle as rd_en is seen by that read
`timescale 1ns/1ns
`default_nettype none

`include "lru_defs.svh"

module lru_top (
   input  logic               clk,
   input  logic               rst,
   input  logic               lru_reset,    // Every set back to identity

   // Read side
   input  logic               rd_en,
   input  lru_pkg::set_addr_t rd_set,

   // Write side
   input  logic               wr_en,
   input  lru_pkg::set_addr_t wr_set,
   input  lru_pkg::way_vec_t  wr_hit_vec,
   input  lru_pkg::way_vec_t  wr_rep_vec,

   // Read result
   output logic               rd_valid,
   output lru_pkg::way_vec_t  rd_way_vec,
   output lru_pkg::way_vec_t  rd_way2_vec
);

   import lru_pkg::*;

   lru_order_t  wr_cur_order;   // Order of wr_set before the write
   lru_order_t  wr_new_order;
   lru_order_t  rd_order;       // Order at the registered read address
   set_addr_t   rd_addr_q;

   // ==============================
   // Array write path
   // ==============================
   lru_state_array state_array_i (
      .clk          (clk),
      .rst          (rst),
      .lru_reset    (lru_reset),
      .wr_en        (wr_en),
      .wr_set       (wr_set),
      .wr_new_order (wr_new_order),
      .rd_addr_q    (rd_addr_q),
      .wr_cur_order (wr_cur_order),
      .rd_order     (rd_order)
   );

   // Kind is for debug only
   lru_order_update order_update_i (
      .cur_order (wr_cur_order),
      .hit_vec   (wr_hit_vec),
      .rep_vec   (wr_rep_vec),
      .new_order (wr_new_order),
      .kind      ()
   );

   // ==============================
   // Array read path
   // ==============================
   lru_read_pipe #(
      .PIPE_STAGES (`LRU_PIPE_STAGES)
   ) read_pipe_i (
      .clk         (clk),
      .rst         (rst),
      .rd_en       (rd_en),
      .rd_set      (rd_set),
      .rd_order    (rd_order),
      .rd_addr_q   (rd_addr_q),
      .rd_valid    (rd_valid),
      .rd_way_vec  (rd_way_vec),
      .rd_way2_vec (rd_way2_vec)
   );

endmodule

`default_nettype wire

/* tb_lru_top.sv */
// Run from the project root so lru_golden.txt is found; read latency checked against LRU_PIPE_STAGES
`timescale 1ns/1ns
`default_nettype none

`include "lru_defs.svh"

module tb_lru_top;

   import lru_pkg::*;

   localparam int RD_TIMEOUT = 20;   // Cycles allowed for outstanding reads

   logic       clk;
   logic       rst;
   logic       lru_reset;
   logic       rd_en;
   set_addr_t  rd_set;
   logic       wr_en;
   set_addr_t  wr_set;
   way_vec_t   wr_hit_vec;
   way_vec_t   wr_rep_vec;
   logic       rd_valid;
   way_vec_t   rd_way_vec;
   way_vec_t   rd_way2_vec;

   // Outstanding reads with the oldest at the front
   string      name_q [$];
   way_vec_t   exp_lru_q [$];
   way_vec_t   exp_lru2_q [$];
   int         issue_q [$];      // Cycle count at the edge that raised rd_en

   int         cycle_cnt     = 0;

   lru_top dut_i (
      .clk         (clk),
      .rst         (rst),
      .lru_reset   (lru_reset),
      .rd_en       (rd_en),
      .rd_set      (rd_set),
      .wr_en       (wr_en),
      .wr_set      (wr_set),
      .wr_hit_vec  (wr_hit_vec),
      .wr_rep_vec  (wr_rep_vec),
      .rd_valid    (rd_valid),
      .rd_way_vec  (rd_way_vec),
      .rd_way2_vec (rd_way2_vec)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   // ==============================
   // Helpers
   // ==============================
   task automatic abort_run();
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check(input string name, input string field,
                        input logic [31:0] expected, input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Error: test %s %s expected %0h actual %0h", name, field, expected, actual);
         abort_run();
      end
   endtask

   // Rest of a comment line in the golden file
   task automatic skip_line(input int fd);
      int ch;
      ch = $fgetc(fd);
      while (ch != 10 && ch != -1) begin
         ch = $fgetc(fd);
      end
   endtask

   task automatic drive_idle();
      @(posedge clk);
      rd_en     <= 1'b0;
      wr_en     <= 1'b0;
      lru_reset <= 1'b0;
   endtask

   // One golden line is one clock cycle of strobes
   task automatic drive_op(input string name, input string op,
                           input logic [31:0] set_val, input logic [31:0] hit_val,
                           input logic [31:0] rep_val, input logic [31:0] exp_lru,
                           input logic [31:0] exp_lru2);
      logic is_read;
      logic is_write;
      is_read  = (op == "R");
      is_write = (op == "W") || (is_read && ((hit_val != 0) || (rep_val != 0)));
      @(posedge clk);
      rd_en      <= is_read;
      rd_set     <= set_addr_t'(set_val);
      wr_en      <= is_write;
      wr_set     <= set_addr_t'(set_val);
      wr_hit_vec <= way_vec_t'(hit_val);
      wr_rep_vec <= way_vec_t'(rep_val);
      lru_reset  <= (op == "L");
      if (is_read) begin
         name_q.push_back(name);
         exp_lru_q.push_back(way_vec_t'(exp_lru));
         exp_lru2_q.push_back(way_vec_t'(exp_lru2));
         issue_q.push_back(cycle_cnt);
      end
   endtask

   task automatic drain_reads();
      int waited;
      waited = 0;
      while (name_q.size() != 0) begin
         if (waited >= RD_TIMEOUT) begin
            $display("Timeout: read results did not arrive within %0d cycles", RD_TIMEOUT);
            abort_run();
         end
         drive_idle();
         waited++;
      end
   endtask

   // ==============================
   // Read result checker
   // ==============================
   always @(posedge clk) begin
      if (!rst && rd_valid) begin
         if (name_q.size() == 0) begin
            $display("rd_valid was raised with no read outstanding");
            abort_run();
         end else begin
            check(name_q[0], "lru", exp_lru_q[0], rd_way_vec);
            check(name_q[0], "lru2", exp_lru2_q[0], rd_way2_vec);
            // rd_valid is seen one edge after it rises
            check(name_q[0], "latency", `LRU_PIPE_STAGES + 1, cycle_cnt - issue_q[0]);
            void'(name_q.pop_front());
            void'(exp_lru_q.pop_front());
            void'(exp_lru2_q.pop_front());
            void'(issue_q.pop_front());
         end
      end
   end

   // ==============================
   // Stimulus from golden file
   // ==============================
   initial begin
      int          fd;
      int          cnt;
      bit          done;
      string       tok;
      string       op;
      logic [31:0] set_val;
      logic [31:0] hit_val;
      logic [31:0] rep_val;
      logic [31:0] exp_lru;
      logic [31:0] exp_lru2;

      rst        <= 1'b1;
      lru_reset  <= 1'b0;
      rd_en      <= 1'b0;
      rd_set     <= '0;
      wr_en      <= 1'b0;
      wr_set     <= '0;
      wr_hit_vec <= '0;
      wr_rep_vec <= '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check("reset", "valid", 0, rd_valid);

      fd = $fopen("lru_golden.txt", "r");
      if (fd == 0) begin
         $display("Could not open lru_golden.txt");
         abort_run();
      end

      done = 1'b0;
      while (!done) begin
         cnt = $fscanf(fd, "%s", tok);
         if (cnt != 1) begin
            done = 1'b1;   // End of file
         end else if (tok.getc(0) == "#") begin
            skip_line(fd);
         end else begin
            cnt = $fscanf(fd, "%s %h %h %h %h %h", op, set_val, hit_val, rep_val,
                          exp_lru, exp_lru2);
            if (cnt != 6 || (op != "R" && op != "W" && op != "L")) begin
               $display("Malformed golden line for test %s", tok);
               abort_run();
            end
            // Reads in a row go out back to back
            if (op != "R") begin
               drain_reads();
            end
            drive_op(tok, op, set_val, hit_val, rep_val, exp_lru, exp_lru2);
         end
      end
      $fclose(fd);
      drain_reads();

      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

/* lru_golden.txt */
# name op set hit rep exp_lru exp_lru2, numbers in hex; op R read, W write, L lru_reset
# R with a nonzero hit or rep also writes that set in the same cycle; W and L ignore exp columns
reset_s0     R 0 0 0 1 2
reset_s5     R 5 0 0 1 2
reset_sf     R f 0 0 1 2
hit_w0       W 3 1 0 0 0
hit_w1       W 3 2 0 0 0
hit_s3       R 3 0 0 4 8
hit_other    R 2 0 0 1 2
rep_w2       W 3 0 4 0 0
rep_s3       R 3 0 0 8 1
rep_w0       W 7 0 1 0 0
rep_s7       R 7 0 0 2 4
inv_all1     W 3 0 f 0 0
inv_s3       R 3 0 0 1 2
inv_s7       R 7 0 0 2 4
glb_touch    W 9 1 0 0 0
glb_pre      R 9 0 0 2 4
glb_reset    L 0 0 0 0 0
glb_s7       R 7 0 0 1 2
glb_s9       R 9 0 0 1 2
glb_s3       R 3 0 0 1 2
same_hit0    R 4 1 0 2 4
same_hit1    R 4 2 0 4 8
b2b_rep0     W a 0 1 0 0
b2b_rep1     W a 0 2 0 0
b2b_rep2     W a 0 4 0 0
b2b_s4       R 4 0 0 4 8
b2b_sa       R a 0 0 8 1
b2b_s0       R 0 0 0 1 2
inv_zero     W a 0 0 0 0
inv_sa       R a 0 0 1 2

/* filelist.f */
+incdir+.
lru_pkg.sv
lru_order_update.sv
lru_state_array.sv
lru_read_pipe.sv
lru_top.sv
tb_lru_top.sv
